//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    typedef logic [31:0] xlen_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [11:0] csr_addr_t;

    // Major opcode of the load group
    localparam opcode_t OPC_LOAD = 7'b0000011;

    // Load and store width codes
    localparam funct3_t LB  = 3'b000;
    localparam funct3_t LH  = 3'b001;
    localparam funct3_t LW  = 3'b010;
    localparam funct3_t LBU = 3'b100;
    localparam funct3_t LHU = 3'b101;
    localparam funct3_t SB  = 3'b000;
    localparam funct3_t SH  = 3'b001;
    localparam funct3_t SW  = 3'b010;

    // Zicsr operations
    localparam funct3_t CSRRW  = 3'b001;
    localparam funct3_t CSRRS  = 3'b010;
    localparam funct3_t CSRRC  = 3'b011;
    localparam funct3_t CSRRWI = 3'b101;
    localparam funct3_t CSRRSI = 3'b110;
    localparam funct3_t CSRRCI = 3'b111;

    // Machine-mode CSRs implemented by the bank
    localparam csr_addr_t MTVEC    = 12'h305;
    localparam csr_addr_t MSCRATCH = 12'h340;
    localparam csr_addr_t MEPC     = 12'h341;
    localparam csr_addr_t MCAUSE   = 12'h342;

endpackage

//--- hw/mem_stage_pkg.sv
package mem_stage_pkg;

    // Where an execute result ends up
    typedef enum logic [1:0] {
        RES_NONE = 2'd0,
        RES_REG  = 2'd1,
        RES_MEM  = 2'd2,
        RES_CSR  = 2'd3
    } res_ctrl_e;

    // Word index into the data RAM
    typedef logic [29:0] word_addr_t;

    // ----------------------------------------
    // Stage boundary records
    // ----------------------------------------
    typedef struct packed {
        logic                  valid;
        res_ctrl_e             res_ctrl;
        rv_isa_pkg::opcode_t   opcode;
        rv_isa_pkg::funct3_t   funct3;
        rv_isa_pkg::xlen_t     alu_res;    // byte address for loads and stores
        rv_isa_pkg::xlen_t     rs1_data;
        rv_isa_pkg::xlen_t     rs2_data;
        rv_isa_pkg::xlen_t     imm;
        rv_isa_pkg::csr_addr_t csr_addr;
    } ex_result_t;

    typedef struct packed {
        logic              valid;
        logic              fault;
        rv_isa_pkg::xlen_t data;
    } wb_t;

    typedef struct packed {
        logic              req;
        logic              wr_en;
        word_addr_t        addr;
        rv_isa_pkg::xlen_t wdata;
    } dmem_req_t;

endpackage

//--- hw/lane_align.sv
`timescale 1ns/1ps

module lane_align (
    input  rv_isa_pkg::funct3_t funct3_i,
    input  logic [1:0]          offset_i,
    input  rv_isa_pkg::xlen_t   old_word_i,
    input  rv_isa_pkg::xlen_t   store_data_i,
    output rv_isa_pkg::xlen_t   merged_word_o,
    output rv_isa_pkg::xlen_t   load_value_o
);
    import rv_isa_pkg::*;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // Lanes picked out of the word read from RAM
    assign byte_lane = old_word_i[{offset_i, 3'b000} +: 8];
    assign half_lane = old_word_i[{offset_i[1], 4'b0000} +: 16];

    // ----------------------------------------
    // Store merge
    // ----------------------------------------
    always_comb begin
        merged_word_o = old_word_i;
        case (funct3_i)
            SB: begin
                merged_word_o[{offset_i, 3'b000} +: 8] = store_data_i[7:0];
            end
            SH: begin
                merged_word_o[{offset_i[1], 4'b0000} +: 16] = store_data_i[15:0];
            end
            SW: begin
                merged_word_o = store_data_i;
            end
            default: begin
                merged_word_o = old_word_i;
            end
        endcase
    end

    // ----------------------------------------
    // Load extract and extend
    // ----------------------------------------
    always_comb begin
        case (funct3_i)
            LB: begin
                load_value_o = {{24{byte_lane[7]}}, byte_lane};
            end
            LH: begin
                load_value_o = {{16{half_lane[15]}}, half_lane};
            end
            LBU: begin
                load_value_o = {24'h000000, byte_lane};
            end
            LHU: begin
                load_value_o = {16'h0000, half_lane};
            end
            default: begin
                load_value_o = old_word_i;
            end
        endcase
    end

endmodule

//--- hw/mem_access.sv
`timescale 1ns/1ps

module mem_access #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_stage_pkg::ex_result_t ex_i,
    input  rv_isa_pkg::xlen_t        dmem_rdata_i,
    input  rv_isa_pkg::xlen_t        csr_rdata_i,
    output mem_stage_pkg::dmem_req_t dmem_req_o,
    output rv_isa_pkg::csr_addr_t    csr_addr_o,
    output logic                     csr_we_o,
    output rv_isa_pkg::xlen_t        csr_wdata_o,
    output mem_stage_pkg::wb_t       wb_o,
    output logic                     hold_o
);
    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    typedef enum logic {
        PH_READ   = 1'b0,
        PH_COMMIT = 1'b1
    } phase_e;

    localparam word_addr_t DMEM_LIMIT = 30'(DMEM_WORDS);

    phase_e phase_q;
    phase_e phase_d;
    logic   is_load;
    logic   is_store;
    logic   aligned;
    logic   in_range;
    logic   mem_ok;
    logic   mem_fault;
    xlen_t  merged_word;
    xlen_t  load_value;

    // ----------------------------------------
    // Classify and check the access
    // ----------------------------------------
    assign is_load  = ex_i.valid && (ex_i.res_ctrl == RES_REG) && (ex_i.opcode == OPC_LOAD);
    assign is_store = ex_i.valid && (ex_i.res_ctrl == RES_MEM);

    // funct3[1:0] gives the access size for loads and stores alike
    always_comb begin
        case (ex_i.funct3[1:0])
            2'b00:   aligned = 1'b1;
            2'b01:   aligned = ~ex_i.alu_res[0];
            2'b10:   aligned = (ex_i.alu_res[1:0] == 2'b00);
            default: aligned = 1'b0;
        endcase
    end

    assign in_range  = (ex_i.alu_res[31:2] < DMEM_LIMIT);
    assign mem_ok    = (is_load || is_store) && aligned && in_range;
    assign mem_fault = (is_load || is_store) && !mem_ok;

    // Two-phase sequencer that reads first and then commits
    assign phase_d = (mem_ok && (phase_q == PH_READ)) ? PH_COMMIT : PH_READ;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= PH_READ;
        end else begin
            phase_q <= phase_d;
        end
    end

    assign hold_o = mem_ok && (phase_q == PH_READ);

    lane_align u_lane_align (
        .funct3_i      (ex_i.funct3),
        .offset_i      (ex_i.alu_res[1:0]),
        .old_word_i    (dmem_rdata_i),
        .store_data_i  (ex_i.rs2_data),
        .merged_word_o (merged_word),
        .load_value_o  (load_value)
    );

    // Stores use the RAM in both phases and loads only in the read phase
    assign dmem_req_o.req   = mem_ok && ((phase_q == PH_READ) || is_store);
    assign dmem_req_o.wr_en = mem_ok && is_store && (phase_q == PH_COMMIT);
    assign dmem_req_o.addr  = ex_i.alu_res[31:2];
    assign dmem_req_o.wdata = merged_word;

    // ----------------------------------------
    // CSR side
    // ----------------------------------------
    assign csr_addr_o = ex_i.csr_addr;
    assign csr_we_o   = ex_i.valid && (ex_i.res_ctrl == RES_CSR);

    always_comb begin
        case (ex_i.funct3)
            CSRRW:  csr_wdata_o = ex_i.rs1_data;
            CSRRWI: csr_wdata_o = ex_i.imm;
            CSRRS, CSRRC, CSRRSI, CSRRCI: csr_wdata_o = ex_i.alu_res;
            default: csr_wdata_o = ex_i.alu_res;
        endcase
    end

    // Writeback selection
    always_comb begin
        wb_o = '0;
        if (mem_fault) begin
            wb_o.valid = 1'b1;
            wb_o.fault = 1'b1;
        end else if (is_load) begin
            wb_o.valid = (phase_q == PH_COMMIT);
            wb_o.data  = load_value;
        end else if (ex_i.valid && (ex_i.res_ctrl == RES_REG)) begin
            wb_o.valid = 1'b1;
            wb_o.data  = ex_i.alu_res;
        end else if (csr_we_o) begin
            wb_o.valid = 1'b1;
            wb_o.data  = csr_rdata_i;
        end
    end

    // A held operation completes in the cycle after the hold
    a_hold_single: assert property (@(posedge clk) disable iff (!rst_n)
        hold_o |=> !hold_o && (dmem_req_o.wr_en || wb_o.valid));

    // The write goes back to the word read in the phase before
    a_write_in_commit: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req_o.wr_en |-> $past(hold_o && !dmem_req_o.wr_en) && $stable(dmem_req_o.addr));

    // Execute side must keep its result while stalled
    a_ex_stable: assert property (@(posedge clk) disable iff (!rst_n)
        hold_o |=> $stable(ex_i));

endmodule

//--- hw/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_stage_pkg::dmem_req_t req_i,
    output rv_isa_pkg::xlen_t        rdata_o
);
    import rv_isa_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    xlen_t mem [DMEM_WORDS];

    // Storage array
    always_ff @(posedge clk) begin
        if (req_i.req && req_i.wr_en) begin
            mem[req_i.addr[AW-1:0]] <= req_i.wdata;
        end
    end

    // Read data valid one cycle after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_o <= '0;
        end else if (req_i.req && !req_i.wr_en) begin
            rdata_o <= mem[req_i.addr[AW-1:0]];
        end
    end

    a_addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        req_i.req |-> (req_i.addr < 30'(DMEM_WORDS)));

endmodule

//--- hw/csr_bank.sv
`timescale 1ns/1ps

module csr_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_isa_pkg::csr_addr_t addr_i,
    input  logic                  we_i,
    input  rv_isa_pkg::xlen_t     wdata_i,
    output rv_isa_pkg::xlen_t     rdata_o
);
    import rv_isa_pkg::*;

    xlen_t mscratch_q;
    xlen_t mtvec_q;
    xlen_t mepc_q;
    xlen_t mcause_q;

    // Zero-cycle read where unknown addresses give zero
    always_comb begin
        case (addr_i)
            MSCRATCH: rdata_o = mscratch_q;
            MTVEC:    rdata_o = mtvec_q;
            MEPC:     rdata_o = mepc_q;
            MCAUSE:   rdata_o = mcause_q;
            default:  rdata_o = '0;
        endcase
    end

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch_q <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (we_i) begin
            case (addr_i)
                MSCRATCH: mscratch_q <= wdata_i;
                // Mode field bit 1 is reserved
                MTVEC:    mtvec_q    <= {wdata_i[31:2], 1'b0, wdata_i[0]};
                // Without compressed instructions mepc stays word aligned
                MEPC:     mepc_q     <= {wdata_i[31:2], 2'b00};
                MCAUSE:   mcause_q   <= wdata_i;
                default:  mscratch_q <= mscratch_q;
            endcase
        end
    end

endmodule

//--- hw/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mem_stage_pkg::ex_result_t ex_i,
    output mem_stage_pkg::wb_t        wb_o,
    output logic                      hold_o
);
    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    dmem_req_t dmem_req;
    xlen_t     dmem_rdata;
    csr_addr_t csr_addr;
    logic      csr_we;
    xlen_t     csr_wdata;
    xlen_t     csr_rdata;

    mem_access #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_mem_access (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_i         (ex_i),
        .dmem_rdata_i (dmem_rdata),
        .csr_rdata_i  (csr_rdata),
        .dmem_req_o   (dmem_req),
        .csr_addr_o   (csr_addr),
        .csr_we_o     (csr_we),
        .csr_wdata_o  (csr_wdata),
        .wb_o         (wb_o),
        .hold_o       (hold_o)
    );

    data_ram #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (dmem_req),
        .rdata_o (dmem_rdata)
    );

    csr_bank u_csr_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr_i  (csr_addr),
        .we_i    (csr_we),
        .wdata_i (csr_wdata),
        .rdata_o (csr_rdata)
    );

endmodule

//--- verification/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    localparam int      WORDS      = 256;
    localparam int      HOLD_LIMIT = 8;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    logic       clk;
    logic       rst_n;
    ex_result_t ex;
    wb_t        wb;
    logic       hold;

    int        errors;
    int        checks;
    xlen_t     mem_model [WORDS];
    xlen_t     csr_model [4];
    funct3_t   csr_ops [6]   = '{CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};
    csr_addr_t csr_addrs [5] = '{MSCRATCH, MTVEC, MEPC, MCAUSE, 12'h7c0};

    mem_subsys_top #(
        .DMEM_WORDS (WORDS)
    ) u_mem_subsys_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_i   (ex),
        .wb_o   (wb),
        .hold_o (hold)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input xlen_t exp, input xlen_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic int csr_slot(input csr_addr_t addr);
        case (addr)
            MSCRATCH: return 0;
            MTVEC:    return 1;
            MEPC:     return 2;
            MCAUSE:   return 3;
            default:  return -1;
        endcase
    endfunction

    // Natural alignment and inside the RAM
    function automatic logic access_ok(input funct3_t f3, input xlen_t addr);
        int size;
        size = 1 << f3[1:0];
        return (addr % size == 0) && (addr < 4 * WORDS);
    endfunction

    function automatic xlen_t load_lane(input funct3_t f3, input xlen_t addr);
        xlen_t shifted;
        shifted = mem_model[addr[9:2]] >> (8 * addr[1:0]);
        case (f3)
            LB:      return xlen_t'($signed(shifted[7:0]));
            LH:      return xlen_t'($signed(shifted[15:0]));
            LBU:     return {24'd0, shifted[7:0]};
            LHU:     return {16'd0, shifted[15:0]};
            default: return mem_model[addr[9:2]];
        endcase
    endfunction

    task automatic model_store(input funct3_t f3, input xlen_t addr, input xlen_t data);
        xlen_t mask;
        int    sh;
        sh = 8 * addr[1:0];
        case (f3)
            SB:      mask = 32'h0000_00ff << sh;
            SH:      mask = 32'h0000_ffff << sh;
            default: mask = 32'hffff_ffff;
        endcase
        mem_model[addr[9:2]] = (mem_model[addr[9:2]] & ~mask) | ((data << sh) & mask);
    endtask

    function automatic ex_result_t make_op(input res_ctrl_e rc, input opcode_t opc,
                                           input funct3_t f3, input xlen_t alu,
                                           input xlen_t rs1, input xlen_t rs2,
                                           input xlen_t imm, input csr_addr_t ca);
        ex_result_t op;
        op.valid    = 1'b1;
        op.res_ctrl = rc;
        op.opcode   = opc;
        op.funct3   = f3;
        op.alu_res  = alu;
        op.rs1_data = rs1;
        op.rs2_data = rs2;
        op.imm      = imm;
        op.csr_addr = ca;
        return op;
    endfunction

    // ----------------------------------------
    // Drive one result and check writeback
    // ----------------------------------------
    task automatic run_op(input string name, input ex_result_t op, input logic exp_valid,
                          input logic exp_fault, input xlen_t exp_data, input int exp_holds);
        int holds;
        holds = 0;
        @(posedge clk);
        ex <= op;
        @(negedge clk);
        while (hold) begin
            holds++;
            if (holds > HOLD_LIMIT) begin
                $display("Timeout: hold_o stayed high too long during %s", name);
                $display("sim failed");
                $finish;
            end
            @(negedge clk);
        end
        check({name, " hold"}, xlen_t'(exp_holds), xlen_t'(holds));
        check({name, " valid"}, xlen_t'(exp_valid), xlen_t'(wb.valid));
        if (exp_valid) begin
            check({name, " fault"}, xlen_t'(exp_fault), xlen_t'(wb.fault));
            check({name, " data"}, exp_data, wb.data);
        end
    endtask

    task automatic store_access(input funct3_t f3, input xlen_t addr, input xlen_t data);
        ex_result_t op;
        op = make_op(RES_MEM, OPC_STORE, f3, addr, '0, data, '0, '0);
        if (access_ok(f3, addr)) begin
            run_op("store", op, 1'b0, 1'b0, '0, 1);
            model_store(f3, addr, data);
        end else begin
            run_op("store fault", op, 1'b1, 1'b1, '0, 0);
        end
    endtask

    task automatic load_access(input string name, input funct3_t f3, input xlen_t addr);
        ex_result_t op;
        op = make_op(RES_REG, OPC_LOAD, f3, addr, '0, '0, '0, '0);
        if (access_ok(f3, addr)) begin
            run_op(name, op, 1'b1, 1'b0, load_lane(f3, addr), 1);
        end else begin
            run_op({name, " fault"}, op, 1'b1, 1'b1, '0, 0);
        end
    endtask

    task automatic readback_all(input string name);
        for (int w = 0; w < WORDS; w++) begin
            load_access(name, LW, xlen_t'(w * 4));
        end
    endtask

    // Execute stage computes alu_res for set and clear
    task automatic csr_access(input string name, input funct3_t f3, input csr_addr_t ca,
                              input xlen_t rs1, input xlen_t imm);
        int    slot;
        xlen_t old_val;
        xlen_t src;
        xlen_t alu;
        xlen_t new_val;
        slot    = csr_slot(ca);
        old_val = (slot >= 0) ? csr_model[slot] : '0;
        src     = f3[2] ? imm : rs1;
        case (f3[1:0])
            2'b10:   alu = old_val | src;
            2'b11:   alu = old_val & ~src;
            default: alu = ~src;
        endcase
        new_val = (f3[1:0] == 2'b01) ? src : alu;
        run_op(name, make_op(RES_CSR, OPC_SYSTEM, f3, alu, rs1, '0, imm, ca),
               1'b1, 1'b0, old_val, 0);
        if (slot == 1) begin
            new_val[1] = 1'b0;
        end
        if (slot == 2) begin
            new_val[1:0] = 2'b00;
        end
        if (slot >= 0) begin
            csr_model[slot] = new_val;
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        xlen_t     addr;
        xlen_t     r;
        funct3_t   f3;
        csr_addr_t ca;
        void'($urandom(83944));
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        ex     = '0;
        foreach (csr_model[i]) begin
            csr_model[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("reset hold", '0, xlen_t'(hold));
        check("reset valid", '0, xlen_t'(wb.valid));
        for (int i = 0; i < 4; i++) begin
            csr_access("reset csr", CSRRS, csr_addrs[i], '0, '0);
        end

        // Known contents everywhere before any partial store
        for (int w = 0; w < WORDS; w++) begin
            store_access(SW, xlen_t'(w * 4), (xlen_t'(w) * 32'h9e37_79b9) ^ 32'h5ac3_0f96);
        end

        repeat (20) begin
            r = $urandom();
            run_op("reg result", make_op(RES_REG, OPC_OP, funct3_t'($urandom_range(0, 7)),
                   r, $urandom(), $urandom(), '0, '0), 1'b1, 1'b0, r, 0);
        end
        run_op("no result", make_op(RES_NONE, OPC_OP, '0, '1, '0, '0, '0, '0),
               1'b0, 1'b0, '0, 0);

        repeat (200) begin
            f3   = funct3_t'($urandom_range(0, 2));
            addr = $urandom_range(0, 4 * WORDS - 1);
            addr = addr & ~xlen_t'((1 << f3) - 1);
            store_access(f3, addr, $urandom());
        end
        readback_all("word readback");

        repeat (40) begin
            addr = xlen_t'($urandom_range(0, WORDS - 1)) << 2;
            for (int off = 0; off < 4; off++) begin
                load_access("load byte", LB, addr + off);
                load_access("load byte unsigned", LBU, addr + off);
                if (off % 2 == 0) begin
                    load_access("load half", LH, addr + off);
                    load_access("load half unsigned", LHU, addr + off);
                end
            end
        end

        // Misaligned or out-of-range accesses leave the RAM untouched
        repeat (30) begin
            f3   = funct3_t'($urandom_range(0, 2));
            addr = $urandom_range(0, 4 * WORDS - 1);
            if (($urandom_range(0, 1) == 0) || (f3 == SB)) begin
                addr = addr + 4 * WORDS + $urandom_range(0, 4000);
            end else if (f3 == SH) begin
                addr[0] = 1'b1;
            end else begin
                addr[1:0] = 2'($urandom_range(1, 3));
            end
            if ($urandom_range(0, 1) == 0) begin
                load_access("fault load", f3, addr);
            end else begin
                store_access(f3, addr, $urandom());
            end
        end
        readback_all("after faults");

        repeat (60) begin
            f3 = csr_ops[$urandom_range(0, 5)];
            ca = csr_addrs[$urandom_range(0, 4)];
            csr_access("csr op", f3, ca, $urandom(), xlen_t'($urandom_range(0, 31)));
            csr_access("csr readback", CSRRS, ca, '0, '0);
        end

        @(posedge clk);
        ex <= '0;
        @(negedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- all.f
hw/rv_isa_pkg.sv
hw/mem_stage_pkg.sv
hw/lane_align.sv
hw/mem_access.sv
hw/data_ram.sv
hw/csr_bank.sv
hw/mem_subsys_top.sv
verification/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - target: any(rtl, test)
    files:
      - hw/rv_isa_pkg.sv
      - hw/mem_stage_pkg.sv
      - hw/lane_align.sv
      - hw/mem_access.sv
      - hw/data_ram.sv
      - hw/csr_bank.sv
      - hw/mem_subsys_top.sv
  - target: test
    files:
      - verification/tb_mem_subsys.sv
